//--- hw/isa_pkg.sv
package isa_pkg;

    // RV32I major opcodes used by the back end
    typedef enum logic [6:0] {
        OP     = 7'b0110011,   // Register-register ALU
        OP_IMM = 7'b0010011,   // Register-immediate ALU
        LOAD   = 7'b0000011,   // Loads
        STORE  = 7'b0100011,   // Stores
        BRANCH = 7'b1100011,   // Conditional branches
        JAL    = 7'b1101111,   // Jump and link
        JALR   = 7'b1100111,   // Jump and link register
        LUI    = 7'b0110111    // Load upper immediate
    } opcode_e;

    // R-type field view of a 32-bit instruction
    typedef struct packed {
        logic [6:0] funct7;    // [31:25]
        logic [4:0] rs2;       // [24:20]
        logic [4:0] rs1;       // [19:15]
        logic [2:0] funct3;    // [14:12]
        logic [4:0] rd;        // [11:7] destination register
        opcode_e    opcode;    // [6:0]
    } instr_t;

endpackage

//--- hw/rob_commit.sv
`timescale 1ns/100ps

module rob_commit #(
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             retire,        // Head entry leaves this cycle
    input  rob_pkg::alloc_t  head_entry,    // Static fields of head
    input  logic [31:0]      head_value,    // Result of head
    output logic             commit_valid,  // One-cycle pulse
    output rob_pkg::commit_t commit
);

    rob_pkg::commit_t rec;                  // Record built from the head
    logic             dest_x0;              // rd is the zero register
    logic             is_branch;

    assign dest_x0 = (head_entry.instr.rd == 5'd0);

    // Control transfers keep their target in the value field
    always_comb begin
        case (head_entry.instr.opcode)
            isa_pkg::BRANCH,
            isa_pkg::JAL,
            isa_pkg::JALR: is_branch = 1'b1;
            default:       is_branch = 1'b0;
        endcase
    end

    always_comb begin
        rec.value     = head_value;
        rec.dest      = head_entry.instr.rd;
        rec.phys_addr = head_entry.phys_addr;
        rec.reg_write = head_entry.reg_write && !dest_x0;
        rec.is_branch = is_branch;
        rec.pc        = head_entry.pc;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit <= rec;                  // Held until next retire
        end
    end

endmodule

//--- hw/rob_ctrl.sv
`timescale 1ns/100ps

module rob_ctrl #(
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc_valid,   // Decode wants an entry
    input  rob_pkg::branch_t br,            // Branch resolution
    input  logic             head_ready,    // Oldest entry has its result
    output logic             alloc_we,      // Allocation accepted this cycle
    output logic             retire,        // Oldest entry leaves this cycle
    output rob_pkg::tag_t    head,          // Oldest live entry
    output rob_pkg::tag_t    tail,          // Next free entry
    output logic             full
);

    typedef logic [rob_pkg::TAG_W:0] cnt_t;    // One extra bit to hold DEPTH

    localparam rob_pkg::tag_t PTR_MASK = rob_pkg::tag_t'(DEPTH - 1);   // Modulo DEPTH
    localparam cnt_t          CNT_FULL = cnt_t'(DEPTH);

    cnt_t          count;         // Live entries
    rob_pkg::tag_t head_inc;      // head + 1 wrapped
    rob_pkg::tag_t tail_inc;      // tail + 1 wrapped
    rob_pkg::tag_t br_tail;       // New tail after a flush
    rob_pkg::tag_t br_dist;       // Branch entry's age from head
    cnt_t          br_count;      // Live entries kept by a flush

    assign head_inc = (head + rob_pkg::tag_t'(1)) & PTR_MASK;
    assign tail_inc = (tail + rob_pkg::tag_t'(1)) & PTR_MASK;

    // Branch entry stays, everything after it is discarded
    assign br_tail  = (br.tag + rob_pkg::tag_t'(1)) & PTR_MASK;
    assign br_dist  = (br.tag - head) & PTR_MASK;
    assign br_count = cnt_t'(br_dist) + cnt_t'(1);    // Counts the branch itself

    assign full = (count == CNT_FULL);

    // Decode is dropped when full or when a branch rewrites the tail
    assign alloc_we = alloc_valid && !full && !br.valid;

    assign retire = (count != '0) && head_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (retire) begin
                head <= head_inc;
            end
            if (br.valid) begin
                tail  <= br_tail;                      // Truncate after branch
                count <= br_count - cnt_t'(retire);    // Head may still retire
            end else begin
                if (alloc_we) begin
                    tail <= tail_inc;
                end
                count <= count + cnt_t'(alloc_we) - cnt_t'(retire);
            end
        end
    end

endmodule

//--- hw/rob_entry_ram.sv
`timescale 1ns/100ps

module rob_entry_ram #(
    parameter int DEPTH = 16
) (
    input  logic            clk,
    input  logic            alloc_we,     // Write the allocation record
    input  rob_pkg::tag_t   tail,         // Write address
    input  rob_pkg::alloc_t alloc,        // Record from decode
    input  rob_pkg::tag_t   head,         // Read address
    output rob_pkg::alloc_t head_entry    // Oldest entry, combinational
);

    localparam int IDX_W = $clog2(DEPTH);

    rob_pkg::alloc_t  mem [DEPTH];        // Static fields per entry
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // Pointers stay below DEPTH, upper tag bits are zero
    assign wr_idx = tail[IDX_W-1:0];
    assign rd_idx = head[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (alloc_we) begin
            mem[wr_idx] <= alloc;
        end
    end

    assign head_entry = mem[rd_idx];      // Only meaningful when count > 0

endmodule

//--- hw/rob_pkg.sv
package rob_pkg;

    // Tag is the entry index, so DEPTH is capped at 2**TAG_W
    localparam int TAG_W = 6;

    typedef logic [TAG_W-1:0] tag_t;

    // Static record written by decode at allocation
    typedef struct packed {
        isa_pkg::instr_t instr;      // Full instruction word
        logic            reg_write;  // Writes a destination register
        logic [6:0]      phys_addr;  // Renamed destination
        logic [31:0]     pc;         // Instruction address
    } alloc_t;

    // Result report from one execution unit
    typedef struct packed {
        logic        valid;          // Single-cycle strobe
        tag_t        tag;            // Entry being completed
        logic [31:0] value;          // Result
    } wb_t;

    // Branch resolution, entry gets the target and younger entries die
    typedef struct packed {
        logic        valid;          // Single-cycle strobe
        tag_t        tag;            // Entry of the resolved branch
        logic [31:0] target;         // Resolved target address
    } branch_t;

    // Retire record handed to the architectural side
    typedef struct packed {
        logic [31:0] value;          // Result or branch target
        logic [4:0]  dest;           // Architectural rd
        logic [6:0]  phys_addr;      // Renamed destination
        logic        reg_write;      // Low for rd x0
        logic        is_branch;      // BRANCH, JAL or JALR
        logic [31:0] pc;             // Instruction address
    } commit_t;

endpackage

//--- hw/rob_result_file.sv
`timescale 1ns/100ps

module rob_result_file #(
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc_we,     // New entry at tail
    input  rob_pkg::tag_t    tail,
    input  rob_pkg::wb_t     alu_wb,
    input  rob_pkg::wb_t     mul_wb,
    input  rob_pkg::wb_t     div_wb,
    input  rob_pkg::branch_t br,
    input  logic             retire,       // Head entry leaves
    input  rob_pkg::tag_t    head,
    input  rob_pkg::tag_t    flush_tail,   // Tail before the flush
    output logic             head_ready,
    output logic [31:0]      head_value
);

    localparam int            IDX_W    = $clog2(DEPTH);
    localparam rob_pkg::tag_t PTR_MASK = rob_pkg::tag_t'(DEPTH - 1);

    logic [DEPTH-1:0] ready;          // Result valid per entry
    logic [DEPTH-1:0] ready_nxt;
    logic [DEPTH-1:0] discard;        // Entries killed by a branch
    logic [31:0]      value [DEPTH];  // Result or branch target
    rob_pkg::tag_t    flush_first;    // First younger entry
    rob_pkg::tag_t    flush_span;     // Number of younger entries

    assign flush_first = (br.tag + rob_pkg::tag_t'(1)) & PTR_MASK;
    assign flush_span  = (flush_tail - flush_first) & PTR_MASK;

    // Wrapped range check against the old tail
    always_comb begin
        discard = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (br.valid &&
                (((rob_pkg::tag_t'(i) - flush_first) & PTR_MASK) < flush_span)) begin
                discard[i] = 1'b1;
            end
        end
    end

    always_comb begin
        ready_nxt = ready;
        if (alloc_we) ready_nxt[tail[IDX_W-1:0]] = 1'b0;          // Fresh entry
        if (retire) ready_nxt[head[IDX_W-1:0]] = 1'b0;            // Slot freed
        if (alu_wb.valid) ready_nxt[alu_wb.tag[IDX_W-1:0]] = 1'b1;
        if (mul_wb.valid) ready_nxt[mul_wb.tag[IDX_W-1:0]] = 1'b1;
        if (div_wb.valid) ready_nxt[div_wb.tag[IDX_W-1:0]] = 1'b1;
        if (br.valid) ready_nxt[br.tag[IDX_W-1:0]] = 1'b1;        // Target is the result
        ready_nxt = ready_nxt & ~discard;                         // Flush wins
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready <= '0;
        end else begin
            ready <= ready_nxt;
        end
    end

    // Result or target per entry, one write port per unit
    always_ff @(posedge clk) begin
        if (alu_wb.valid) value[alu_wb.tag[IDX_W-1:0]] <= alu_wb.value;
        if (mul_wb.valid) value[mul_wb.tag[IDX_W-1:0]] <= mul_wb.value;
        if (div_wb.valid) value[div_wb.tag[IDX_W-1:0]] <= div_wb.value;
        if (br.valid) value[br.tag[IDX_W-1:0]] <= br.target;
    end

    assign head_ready = ready[head[IDX_W-1:0]];
    assign head_value = value[head[IDX_W-1:0]];

endmodule

//--- hw/rob_top.sv
`timescale 1ns/100ps

module rob_top #(
    parameter int DEPTH = 16                 // Power of two, 4 to 64
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc_valid,    // Decode strobe
    input  rob_pkg::alloc_t  alloc,
    output rob_pkg::tag_t    alloc_tag,      // Tag of the next allocation
    output logic             full,
    input  rob_pkg::wb_t     alu_wb,
    input  rob_pkg::wb_t     mul_wb,
    input  rob_pkg::wb_t     div_wb,
    input  rob_pkg::branch_t br,
    output logic             commit_valid,
    output rob_pkg::commit_t commit
);

    logic            alloc_we;
    logic            retire;
    logic            head_ready;
    rob_pkg::tag_t   head;
    rob_pkg::tag_t   tail;
    rob_pkg::alloc_t head_entry;
    logic [31:0]     head_value;

    assign alloc_tag = tail;                 // Tag is the tail index

    rob_ctrl #(.DEPTH(DEPTH)) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .br          (br),
        .head_ready  (head_ready),
        .alloc_we    (alloc_we),
        .retire      (retire),
        .head        (head),
        .tail        (tail),
        .full        (full)
    );

    rob_entry_ram #(.DEPTH(DEPTH)) u_entry_ram (
        .clk         (clk),
        .alloc_we    (alloc_we),
        .tail        (tail),
        .alloc       (alloc),
        .head        (head),
        .head_entry  (head_entry)
    );

    rob_result_file #(.DEPTH(DEPTH)) u_result_file (
        .clk         (clk),
        .rst         (rst),
        .alloc_we    (alloc_we),
        .tail        (tail),
        .alu_wb      (alu_wb),
        .mul_wb      (mul_wb),
        .div_wb      (div_wb),
        .br          (br),
        .retire      (retire),
        .head        (head),
        .flush_tail  (tail),                 // Tail before the flush edge
        .head_ready  (head_ready),
        .head_value  (head_value)
    );

    rob_commit #(.DEPTH(DEPTH)) u_commit (
        .clk          (clk),
        .rst          (rst),
        .retire       (retire),
        .head_entry   (head_entry),
        .head_value   (head_value),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module rob_tb -o rob_sim

out=$(./obj_dir/rob_sim)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

//--- tb.f
hw/isa_pkg.sv
hw/rob_pkg.sv
hw/rob_ctrl.sv
hw/rob_entry_ram.sv
hw/rob_result_file.sv
hw/rob_commit.sv
hw/rob_top.sv
verification/rob_tb.sv

//--- verification/rob_tb.sv
`timescale 1ns/100ps

module rob_tb;

    localparam int DEPTH      = 16;
    localparam int MAX_CYCLES = 4000;       // About four times the total test length

    // Model view of one live entry
    typedef struct packed {
        rob_pkg::tag_t   tag;
        rob_pkg::alloc_t rec;
        logic            ready;
        logic [31:0]     value;
    } ent_t;

    logic             clk;
    logic             rst;
    logic             alloc_valid;
    rob_pkg::alloc_t  alloc;
    rob_pkg::tag_t    alloc_tag;
    logic             full;
    rob_pkg::wb_t     alu_wb;
    rob_pkg::wb_t     mul_wb;
    rob_pkg::wb_t     div_wb;
    rob_pkg::branch_t br;
    logic             commit_valid;
    rob_pkg::commit_t commit;

    ent_t             q [$];                // Live entries, oldest first
    rob_pkg::tag_t    m_tail;               // Model tail
    logic             exp_valid;            // Retire predicted at the last edge
    rob_pkg::commit_t exp_commit;
    logic [15:0]      lfsr;
    int               cycle_cnt = 0;
    int               err_count;
    int               n_checks;
    int               model_commits;
    int               dut_commits;

    rob_top #(.DEPTH(DEPTH)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;              // 8 ns period
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int rand_below(int n);
        return int'(rand_bits(8)) % n;
    endfunction

    function automatic logic is_ctrl(isa_pkg::opcode_e op);
        return (op == isa_pkg::BRANCH) || (op == isa_pkg::JAL) || (op == isa_pkg::JALR);
    endfunction

    function automatic isa_pkg::opcode_e pick_opcode(logic ctrl, int sel);
        isa_pkg::opcode_e op;
        if (ctrl) begin
            case (sel % 3)
                0:       op = isa_pkg::BRANCH;
                1:       op = isa_pkg::JAL;
                default: op = isa_pkg::JALR;
            endcase
        end else begin
            case (sel % 5)
                0:       op = isa_pkg::OP;
                1:       op = isa_pkg::OP_IMM;
                2:       op = isa_pkg::LOAD;
                3:       op = isa_pkg::STORE;
                default: op = isa_pkg::LUI;
            endcase
        end
        return op;
    endfunction

    function automatic rob_pkg::alloc_t rand_alloc(logic ctrl);
        rob_pkg::alloc_t a;
        a.instr.funct7 = 7'(rand_bits(7));
        a.instr.rs2    = 5'(rand_bits(5));
        a.instr.rs1    = 5'(rand_bits(5));
        a.instr.funct3 = 3'(rand_bits(3));
        a.instr.rd     = 5'(rand_bits(5));
        a.instr.opcode = pick_opcode(ctrl, rand_below(15));
        a.reg_write    = 1'(rand_bits(1));
        a.phys_addr    = 7'(rand_bits(7));
        a.pc           = {30'(rand_bits(30)), 2'b00};   // Word aligned
        return a;
    endfunction

    // Commit record as decode and the execution units defined it
    function automatic rob_pkg::commit_t build_commit(ent_t e);
        rob_pkg::commit_t c;
        c.value     = e.value;
        c.dest      = e.rec.instr.rd;
        c.phys_addr = e.rec.phys_addr;
        c.reg_write = e.rec.reg_write && (e.rec.instr.rd != 5'd0);   // x0 never written
        c.is_branch = is_ctrl(e.rec.instr.opcode);
        c.pc        = e.rec.pc;
        return c;
    endfunction

    function automatic int find_tag(rob_pkg::tag_t t);
        for (int k = 0; k < q.size(); k++) begin
            if (q[k].tag == t) return k;
        end
        return -1;
    endfunction

    task automatic check_commit(logic got_v, rob_pkg::commit_t got,
                                logic exp_v, rob_pkg::commit_t exp);
        n_checks++;
        if (got_v !== exp_v) begin
            $display("[FAIL] %0d ns: commit_valid is %b, expected %b", $time, got_v, exp_v);
            err_count++;
        end else if (exp_v && (got !== exp)) begin
            $display("[FAIL] %0d ns: commit is %h, expected %h", $time, got, exp);
            err_count++;
        end
    endtask

    task automatic check_tag(rob_pkg::tag_t got, rob_pkg::tag_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("[FAIL] %0d ns: alloc_tag is %0d, expected %0d", $time, got, exp);
            err_count++;
        end
    endtask

    task automatic check_full(logic got, logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("[FAIL] %0d ns: full is %b, expected %b", $time, got, exp);
            err_count++;
        end
    endtask

    task automatic apply_wb(rob_pkg::wb_t w);
        ent_t e;
        int   idx;
        idx = find_tag(w.tag);
        if (w.valid && idx >= 0) begin
            e       = q[idx];
            e.ready = 1'b1;
            e.value = w.value;
            q[idx]  = e;
        end
    endtask

    // Effect of the coming rising edge on the model
    task automatic model_edge();
        ent_t e;
        int   idx;
        logic was_full;
        was_full  = (q.size() == DEPTH);    // Retire this cycle does not free a slot yet
        exp_valid = 1'b0;
        if (q.size() != 0 && q[0].ready) begin
            exp_valid  = 1'b1;
            exp_commit = build_commit(q[0]);
            void'(q.pop_front());
            model_commits++;
        end
        apply_wb(alu_wb);
        apply_wb(mul_wb);
        apply_wb(div_wb);
        if (br.valid) begin
            apply_wb(rob_pkg::wb_t'(br));   // Same layout, target is the value
            idx = find_tag(br.tag);
            while (idx >= 0 && q.size() > idx + 1) void'(q.pop_back());
            m_tail = rob_pkg::tag_t'((int'(br.tag) + 1) % DEPTH);
        end else if (alloc_valid && !was_full) begin
            e.tag   = m_tail;
            e.rec   = alloc;
            e.ready = 1'b0;
            e.value = '0;
            q.push_back(e);
            m_tail  = rob_pkg::tag_t'((int'(m_tail) + 1) % DEPTH);
        end
    endtask

    task automatic run_cycle();
        model_edge();
        @(posedge clk);
        @(negedge clk);
        if (commit_valid) dut_commits++;
        check_commit(commit_valid, commit, exp_valid, exp_commit);
        check_tag(alloc_tag, m_tail);
        check_full(full, q.size() == DEPTH);
        alloc_valid = 1'b0;                 // Strobes last one cycle
        alu_wb      = '0;
        mul_wb      = '0;
        div_wb      = '0;
        br          = '0;
    endtask

    task automatic drive_alloc(logic ctrl);
        alloc_valid = 1'b1;
        alloc       = rand_alloc(ctrl);
    endtask

    // Control transfers resolve on the branch port, others on a random free unit
    task automatic complete_entry(int idx);
        ent_t         e;
        rob_pkg::wb_t w;
        int           p;
        logic         done;
        e    = q[idx];
        done = 1'b0;
        if (is_ctrl(e.rec.instr.opcode)) begin
            if (!br.valid) begin
                br.valid  = 1'b1;
                br.tag    = e.tag;
                br.target = {30'(rand_bits(30)), 2'b00};
            end
        end else begin
            w.valid = 1'b1;
            w.tag   = e.tag;
            w.value = rand_bits(32);
            p       = rand_below(3);
            for (int k = 0; k < 3; k++) begin
                if (!done && (p + k) % 3 == 0 && !alu_wb.valid) begin
                    alu_wb = w;
                    done   = 1'b1;
                end
                if (!done && (p + k) % 3 == 1 && !mul_wb.valid) begin
                    mul_wb = w;
                    done   = 1'b1;
                end
                if (!done && (p + k) % 3 == 2 && !div_wb.valid) begin
                    div_wb = w;
                    done   = 1'b1;
                end
            end
        end
    endtask

    task automatic complete_some(int max_n);
        int pend [$];
        int j;
        for (int k = 0; k < q.size(); k++) begin
            if (!q[k].ready) pend.push_back(k);
        end
        for (int n = 0; n < max_n && pend.size() != 0; n++) begin
            j = rand_below(pend.size());    // Random completion order
            complete_entry(pend[j]);
            pend.delete(j);
        end
    endtask

    task automatic drain_all();
        while (q.size() != 0 || exp_valid) begin
            complete_some(3);
            run_cycle();
        end
    endtask

    task automatic report_test(int num, string name, int errs0, int commits0, int exp_n);
        if (exp_n >= 0 && dut_commits - commits0 != exp_n) begin
            $display("Test %0d retired %0d entries instead of %0d",
                     num, dut_commits - commits0, exp_n);
            err_count++;
        end
        $display("test %0d %s: %0d commits, %0d errors",
                 num, name, dut_commits - commits0, err_count - errs0);
    endtask

    initial begin
        int            errs0;
        int            commits0;
        rob_pkg::tag_t tag0;
        rob_pkg::tag_t br_tag;
        rst           = 1'b1;
        alloc_valid   = 1'b0;
        alloc         = '0;
        alu_wb        = '0;
        mul_wb        = '0;
        div_wb        = '0;
        br            = '0;
        lfsr          = 16'd56703;
        m_tail        = '0;
        exp_valid     = 1'b0;
        exp_commit    = '0;
        err_count     = 0;
        n_checks      = 0;
        model_commits = 0;
        dut_commits   = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errs0    = err_count;               // 12 entries completed out of order
        commits0 = dut_commits;
        repeat (12) begin
            drive_alloc(1'b0);
            run_cycle();
        end
        drain_all();
        report_test(1, "in-order retire", errs0, commits0, 12);

        errs0    = err_count;
        commits0 = dut_commits;
        tag0     = m_tail;
        repeat (DEPTH) begin
            drive_alloc(1'b0);
            run_cycle();
        end
        check_full(full, 1'b1);
        drive_alloc(1'b0);                  // Dropped while full
        run_cycle();
        check_tag(alloc_tag, tag0);
        check_full(full, 1'b1);
        drain_all();
        report_test(2, "tags and full", errs0, commits0, DEPTH);

        errs0    = err_count;
        commits0 = dut_commits;
        for (int k = 0; k < 6; k++) begin
            drive_alloc(1'b0);
            if (k == 2) alloc.instr.opcode = isa_pkg::BRANCH;
            run_cycle();
        end
        br_tag = q[2].tag;
        for (int k = 5; k >= 2; k--) begin  // Younger ones ready before the flush
            complete_entry(k);
            run_cycle();
        end
        check_tag(alloc_tag, rob_pkg::tag_t'((int'(br_tag) + 1) % DEPTH));
        drain_all();
        report_test(3, "branch flush", errs0, commits0, 3);

        errs0    = err_count;
        commits0 = dut_commits;
        for (int k = 0; k < 8; k++) begin
            drive_alloc(1'b0);
            alloc.instr.rd  = (k % 3 == 0) ? 5'd0 : 5'(k * 3 + 1);
            alloc.reg_write = (k != 4);
            run_cycle();
        end
        drain_all();
        report_test(4, "commit fields", errs0, commits0, 8);

        errs0    = err_count;
        commits0 = dut_commits;
        for (int c = 0; c < 700; c++) begin
            if (rand_below(4) != 0) drive_alloc(rand_below(8) == 0);
            if (rand_below(2) != 0) complete_some(1 + rand_below(3));
            run_cycle();
        end
        drain_all();
        if (dut_commits != model_commits) begin
            $display("Commit count mismatch: DUT retired %0d entries, model expects %0d",
                     dut_commits, model_commits);
            err_count++;
        end
        report_test(5, "random mix", errs0, commits0, -1);

        $display("%0d checks, %0d errors, %0d commits", n_checks, err_count, dut_commits);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
